//--- hdl/s16_pkg.sv
// Bus request and response structs, fetch-kind and region enums, memory map constants
package s16_pkg;

    // Function code of a CPU cycle
    typedef enum logic [1:0] {
        fetch_op,
        fetch_data,
        fetch_iack
    } fetch_kind_t;

    typedef struct packed {
        logic [23:1] addr;          // Word address
        logic        rnw;           // 1 for read
        logic [1:0]  be_n;          // [1] upper, [0] lower, active low
        logic [15:0] wdata;
        fetch_kind_t kind;
    } bus_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        berr;
    } bus_rsp_t;

    typedef enum logic [3:0] {
        reg_none,
        reg_rom,
        reg_vram,
        reg_char,
        reg_obj,
        reg_pal,
        reg_io,
        reg_wdog,
        reg_ram
    } region_t;

    // Memory map, compared against address bits 23-16
    localparam logic [7:0] MAP_ROM_LAST = 8'h03;   // ROM spans 00-03
    localparam logic [7:0] MAP_VRAM     = 8'h40;
    localparam logic [7:0] MAP_CHAR     = 8'h41;
    localparam logic [7:0] MAP_OBJ      = 8'h44;
    localparam logic [7:0] MAP_PAL      = 8'h84;
    localparam logic [7:0] MAP_IO_FIRST = 8'hc4;
    localparam logic [7:0] MAP_IO_LAST  = 8'hc5;
    localparam logic [7:0] MAP_WDOG     = 8'hc6;
    localparam logic [7:0] MAP_RAM      = 8'hc7;

    // I/O blocks on address bits 13-12
    localparam logic [1:0] IO_BLK_PPI = 2'd0;
    localparam logic [1:0] IO_BLK_CAB = 2'd1;
    localparam logic [1:0] IO_BLK_DIP = 2'd2;

    // Selects on address bits 2-1
    localparam logic [1:0] PPI_PORT_A = 2'd0;   // Sound latch
    localparam logic [1:0] PPI_PORT_B = 2'd1;
    localparam logic [1:0] PPI_PORT_C = 2'd2;
    localparam logic [1:0] CAB_SYS    = 2'd0;   // Coins, service, start
    localparam logic [1:0] CAB_JOY1   = 2'd1;
    localparam logic [1:0] CAB_JOY2   = 2'd3;

    localparam logic [15:0] OPEN_BUS = 16'hffff;

endpackage

//--- hdl/s16_addr_dec.sv
// Registered address decoder for the System 16A memory map
`timescale 1ns/1ps

module s16_addr_dec (
    input  logic             clk,
    input  logic             rst,
    input  logic [23:1]      addr,
    input  logic             start,
    output s16_pkg::region_t region,
    output logic             region_ok
);
    import s16_pkg::*;

    logic [7:0] page;
    region_t    hit;

    assign page = addr[23:16];

    always_comb begin
        if (page <= MAP_ROM_LAST) begin
            hit = reg_rom;      // Bit 18 clear inside 00-03
        end else if (page == MAP_VRAM) begin
            hit = reg_vram;
        end else if (page == MAP_CHAR) begin
            hit = reg_char;
        end else if (page == MAP_OBJ) begin
            hit = reg_obj;
        end else if (page == MAP_PAL) begin
            hit = reg_pal;
        end else if (page >= MAP_IO_FIRST && page <= MAP_IO_LAST) begin
            hit = reg_io;
        end else if (page == MAP_WDOG) begin
            hit = reg_wdog;
        end else if (page == MAP_RAM) begin
            hit = reg_ram;
        end else begin
            hit = reg_none;     // Unmapped, ends in bus error
        end
    end

    // One-cycle result strobe per accepted cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region    <= reg_none;
            region_ok <= 1'b0;
        end else begin
            region_ok <= start;
            if (start) region <= hit;
        end
    end

endmodule

//--- hdl/s16_bus_ctrl.sv
// Bus cycle FSM with request holding, chip selects, wait sequencing and response capture
`timescale 1ns/1ps

module s16_bus_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  s16_pkg::bus_req_t req,
    input  s16_pkg::region_t  region,
    input  logic              region_ok,
    input  logic              ram_ok,
    input  logic              dec_ok,
    input  logic [15:0]       rom_word,
    input  logic [15:0]       ram_data,
    input  logic [15:0]       char_dout,
    input  logic [15:0]       obj_dout,
    input  logic [15:0]       pal_dout,
    input  logic [7:0]        io_dout,
    output logic              req_ready,
    output s16_pkg::bus_req_t held_req,
    output logic              rsp_valid,
    output s16_pkg::bus_rsp_t rsp,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              char_cs,
    output logic              obj_cs,
    output logic              pal_cs,
    output logic              io_cs,
    output logic              iack
);
    import s16_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_access,
        st_wait,
        st_respond
    } state_t;

    state_t      state;
    region_t     cur_region;
    logic        accept;
    logic        sel_on;
    logic        done;
    logic [15:0] rd_word;

    assign req_ready = state == st_idle;
    assign accept    = req_valid && req_ready;
    assign iack      = accept && req.kind == fetch_iack;    // Clears the pending IRQ at once
    assign rsp_valid = state == st_respond;

    // Selects stay up through access and wait
    assign sel_on  = state == st_access || state == st_wait;
    assign rom_cs  = sel_on && cur_region == reg_rom;
    assign ram_cs  = sel_on && cur_region == reg_ram;
    assign vram_cs = sel_on && cur_region == reg_vram;
    assign char_cs = sel_on && cur_region == reg_char;
    assign obj_cs  = sel_on && cur_region == reg_obj;
    assign pal_cs  = sel_on && cur_region == reg_pal;
    assign io_cs   = sel_on && cur_region == reg_io;

    // End of wait and data source per region
    always_comb begin
        done    = state == st_wait;     // Fixed latency regions
        rd_word = OPEN_BUS;
        case (cur_region)
            reg_none: done = 1'b1;      // Bus error right after access
            reg_rom: begin
                done    = dec_ok;
                rd_word = rom_word;
            end
            reg_ram, reg_vram: begin
                done    = ram_ok;
                rd_word = ram_data;
            end
            reg_char: rd_word = char_dout;
            reg_obj:  rd_word = obj_dout;
            reg_pal:  rd_word = pal_dout;
            reg_io:   rd_word = {8'hff, io_dout};
            default:  rd_word = OPEN_BUS;   // Watchdog
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            cur_region <= reg_none;
        end else begin
            case (state)
                st_idle:
                    if (accept) state <= req.kind == fetch_iack ? st_respond : st_decode;
                st_decode:
                    if (region_ok) begin
                        cur_region <= region;
                        state      <= st_access;
                    end
                st_access, st_wait:
                    state <= done ? st_respond : st_wait;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
            rsp      <= '{rdata: OPEN_BUS, berr: 1'b0};   // Interrupt ack answer
        end else if (sel_on && done) begin
            rsp.rdata <= held_req.rnw ? rd_word : OPEN_BUS;
            rsp.berr  <= cur_region == reg_none;
        end
    end

endmodule

//--- hdl/s16_cab_io.sv
// Cabinet inputs, DIP switches and 8255-style port registers with readback
`timescale 1ns/1ps

module s16_cab_io (
    input  logic              clk,
    input  logic              rst,
    input  logic              io_cs,
    input  s16_pkg::bus_req_t held_req,
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic              snd_ack,
    output logic [7:0]        io_dout,
    output logic [7:0]        snd_latch,
    output logic              snd_irqn,
    output logic              flip,
    output logic              colscr_en,
    output logic              rowscr_en
);
    import s16_pkg::*;

    logic [7:0] port_a;
    logic [7:0] port_b;
    logic [7:0] port_c;
    logic [1:0] blk;
    logic [1:0] sel;
    logic       port_wr;
    logic [7:0] rd_mux;

    // Board wiring of the joystick bits
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    assign blk     = held_req.addr[13:12];
    assign sel     = held_req.addr[2:1];
    assign port_wr = io_cs && !held_req.rnw && !held_req.be_n[0] && blk == IO_BLK_PPI;

    assign snd_latch = port_a;
    assign flip      = port_b[7];
    assign snd_irqn  = port_c[7];
    assign colscr_en = port_c[2];
    assign rowscr_en = port_c[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_a <= 8'hff;
            port_b <= 8'hff;
            port_c <= 8'hff;
        end else if (port_wr) begin
            case (sel)
                PPI_PORT_A: port_a <= held_req.wdata[7:0];
                PPI_PORT_B: port_b <= held_req.wdata[7:0];
                PPI_PORT_C: port_c <= held_req.wdata[7:0];
                default: ;      // Control word ignored
            endcase
        end
    end

    always_comb begin
        rd_mux = 8'hff;
        case (blk)
            IO_BLK_PPI:
                case (sel)
                    PPI_PORT_A: rd_mux = port_a;
                    PPI_PORT_B: rd_mux = port_b;
                    PPI_PORT_C: rd_mux = {port_c[7], snd_ack, port_c[5:0]};
                    default:    rd_mux = 8'hff;
                endcase
            IO_BLK_CAB:
                case (sel)
                    CAB_SYS:  rd_mux = {2'b11, start_button, service, 1'b1, coin_input};
                    CAB_JOY1: rd_mux = sort_joy(joystick1);
                    CAB_JOY2: rd_mux = sort_joy(joystick2);
                    default:  rd_mux = 8'hff;
                endcase
            IO_BLK_DIP: rd_mux = held_req.addr[1] ? dipsw_b : dipsw_a;
            default:    rd_mux = 8'hff;
        endcase
    end

    // Read byte ready one cycle after select
    always_ff @(posedge clk) begin
        io_dout <= io_cs ? rd_mux : 8'hff;
    end

endmodule

//--- hdl/s16_rom_dec.sv
// Programmable opcode and data key tables with registered ROM word decryption
`timescale 1ns/1ps

module s16_rom_dec #(
    parameter int KEY_BITS = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dec_en,
    input  logic              prog_we,
    input  logic [4:0]        prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              rom_ok,
    input  logic [15:0]       rom_data,
    input  s16_pkg::bus_req_t held_req,
    output logic              dec_ok,
    output logic [15:0]       rom_word
);
    import s16_pkg::*;

    localparam int KEY_DEPTH = 2 ** KEY_BITS;

    logic [7:0]          key_op  [KEY_DEPTH];
    logic [7:0]          key_dat [KEY_DEPTH];
    logic [KEY_BITS-1:0] prog_idx;
    logic [KEY_BITS-1:0] rd_idx;
    logic [7:0]          key;

    assign prog_idx = prog_addr[KEY_BITS-1:0];
    assign rd_idx   = held_req.addr[KEY_BITS:1];

    // Bit above the index picks the data half
    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog_addr[KEY_BITS]) begin
                key_dat[prog_idx] <= prog_data;
            end else begin
                key_op[prog_idx] <= prog_data;
            end
        end
    end

    assign key = held_req.kind == fetch_op ? key_op[rd_idx] : key_dat[rd_idx];

    always_ff @(posedge clk) begin
        if (rom_ok) rom_word <= dec_en ? rom_data ^ {key, key} : rom_data;
    end

    // Word valid one cycle after rom_ok
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_ok <= 1'b0;
        end else begin
            dec_ok <= rom_ok;
        end
    end

endmodule

//--- hdl/s16_vblank_irq.sv
// VBLANK interrupt request, set on a chosen line and released by acknowledge
`timescale 1ns/1ps

module s16_vblank_irq #(
    parameter int VBLANK_LINE = 223
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic       iack,
    output logic       irq_n
);
    logic hstart_l;
    logic fire;

    // Line start on the chosen line
    assign fire = hstart && !hstart_l && vdump == 9'(VBLANK_LINE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hstart_l <= 1'b0;
            irq_n    <= 1'b1;
        end else begin
            hstart_l <= hstart;
            if (iack) begin
                irq_n <= 1'b1;      // Acknowledge wins over a new edge
            end else if (fire) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/s16_main.sv
// Main CPU bus glue top level with controller, decoder, I/O, ROM decryption and IRQ
`timescale 1ns/1ps

module s16_main #(
    parameter int VBLANK_LINE = 223,
    parameter int KEY_BITS    = 4
) (
    input  logic              clk,
    input  logic              rst,
    // Bus master port
    input  logic              req_valid,
    input  s16_pkg::bus_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output s16_pkg::bus_rsp_t rsp,
    // External memories
    output logic              rom_cs,
    output logic [17:1]       rom_addr,
    input  logic [15:0]       rom_data,
    input  logic              rom_ok,
    output logic              ram_cs,
    output logic              vram_cs,
    input  logic [15:0]       ram_data,
    input  logic              ram_ok,
    output logic [12:1]       mem_addr,
    output logic [15:0]       mem_wdata,
    output logic [1:0]        mem_we_n,
    // Video chips
    output logic              char_cs,
    output logic              obj_cs,
    output logic              pal_cs,
    input  logic [15:0]       char_dout,
    input  logic [15:0]       obj_dout,
    input  logic [15:0]       pal_dout,
    input  logic [8:0]        vdump,
    input  logic              hstart,
    output logic              irq_n,
    // Cabinet
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic              snd_ack,
    output logic [7:0]        snd_latch,
    output logic              snd_irqn,
    output logic              flip,
    output logic              colscr_en,
    output logic              rowscr_en,
    // Key table programming
    input  logic              dec_en,
    input  logic              prog_we,
    input  logic [4:0]        prog_addr,
    input  logic [7:0]        prog_data
);
    import s16_pkg::*;

    bus_req_t    held_req;
    region_t     region;
    logic        region_ok;
    logic        dec_start;
    logic        dec_ok;
    logic [15:0] rom_word;
    logic        io_cs;
    logic [7:0]  io_dout;
    logic        iack;

    assign dec_start = req_valid && req_ready;
    assign mem_addr  = held_req.addr[12:1];
    assign rom_addr  = held_req.addr[17:1];
    assign mem_wdata = held_req.wdata;
    assign mem_we_n  = held_req.be_n | {2{held_req.rnw}};  // No strobes on reads

    s16_bus_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .region(region), .region_ok(region_ok), .ram_ok(ram_ok), .dec_ok(dec_ok),
        .rom_word(rom_word), .ram_data(ram_data), .char_dout(char_dout),
        .obj_dout(obj_dout), .pal_dout(pal_dout), .io_dout(io_dout),
        .req_ready(req_ready), .held_req(held_req), .rsp_valid(rsp_valid), .rsp(rsp),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .obj_cs(obj_cs), .pal_cs(pal_cs), .io_cs(io_cs), .iack(iack)
    );

    // Decodes straight from the incoming request
    s16_addr_dec u_dec (
        .clk(clk), .rst(rst), .addr(req.addr), .start(dec_start),
        .region(region), .region_ok(region_ok)
    );

    s16_cab_io u_io (
        .clk(clk), .rst(rst), .io_cs(io_cs), .held_req(held_req),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .snd_ack(snd_ack), .io_dout(io_dout), .snd_latch(snd_latch), .snd_irqn(snd_irqn),
        .flip(flip), .colscr_en(colscr_en), .rowscr_en(rowscr_en)
    );

    s16_rom_dec #(.KEY_BITS(KEY_BITS)) u_rom_dec (
        .clk(clk), .rst(rst), .dec_en(dec_en), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .rom_ok(rom_ok),
        .rom_data(rom_data), .held_req(held_req), .dec_ok(dec_ok), .rom_word(rom_word)
    );

    s16_vblank_irq #(.VBLANK_LINE(VBLANK_LINE)) u_irq (
        .clk(clk), .rst(rst), .vdump(vdump), .hstart(hstart), .iack(iack), .irq_n(irq_n)
    );

endmodule

//--- bench/s16_main_properties.sv
// Concurrent protocol assertions for s16_main and the bind that attaches them
`timescale 1ns/1ps

module s16_main_properties (
    input logic              clk,
    input logic              rst,
    input logic              req_valid,
    input logic              req_ready,
    input logic              rsp_valid,
    input s16_pkg::bus_req_t req,
    input logic              rom_cs,
    input logic              ram_cs,
    input logic              vram_cs,
    input logic              char_cs,
    input logic              obj_cs,
    input logic              pal_cs,
    input logic              io_cs
);
    import s16_pkg::*;

    logic [6:0] sels;
    logic       accept;
    logic       fixed_hit;
    logic       busy;
    int         fail_count = 0;

    assign sels   = {rom_cs, ram_cs, vram_cs, char_cs, obj_cs, pal_cs, io_cs};
    assign accept = req_valid && req_ready;

    // Video chips, I/O and watchdog have no wait input
    assign fixed_hit = accept && req.kind != fetch_iack &&
        req.addr[23:16] inside {MAP_CHAR, MAP_OBJ, MAP_PAL, MAP_IO_FIRST, MAP_IO_LAST, MAP_WDOG};

    // Cycle outstanding from acceptance until its response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (rsp_valid) begin
            busy <= 1'b0;
        end
    end

    rsp_single: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
        else begin
            $error("rsp_valid held for more than one cycle");
            fail_count++;
        end

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sels))
        else begin
            $error("more than one chip select active");
            fail_count++;
        end

    // Decode, access, wait, then respond
    fixed_lat: assert property (@(posedge clk) disable iff (rst)
        fixed_hit |=> !rsp_valid [*3] ##1 rsp_valid)
        else begin
            $error("fixed latency response not on time");
            fail_count++;
        end

    no_accept: assert property (@(posedge clk) disable iff (rst) busy |-> !req_ready)
        else begin
            $error("req_ready high while a bus cycle is still outstanding");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk) rst |-> sels == '0 && !rsp_valid && req_ready)
        else begin
            $error("outputs active during reset");
            fail_count++;
        end

endmodule

bind s16_main s16_main_properties u_props (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .req(req), .rom_cs(rom_cs),
    .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs), .obj_cs(obj_cs),
    .pal_cs(pal_cs), .io_cs(io_cs)
);

//--- bench/s16_main_tb.sv
// Testbench for s16_main with bus master tasks, memory models, checks and watchdog
`timescale 1ns/1ps

module s16_main_tb;
    import s16_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 80;     // Bus cycles and programming steps, rounded up
    localparam logic [15:0] CHAR_K = 16'h1111;
    localparam logic [15:0] OBJ_K  = 16'h2222;
    localparam logic [15:0] PAL_K  = 16'h4444;

    logic clk, rst, req_valid, req_ready, rsp_valid, rom_cs, rom_ok, ram_cs, vram_cs, ram_ok;
    logic char_cs, obj_cs, pal_cs, hstart, irq_n, service, snd_ack, snd_irqn, flip;
    logic colscr_en, rowscr_en, dec_en, prog_we;
    logic [17:1] rom_addr;
    logic [12:1] mem_addr;
    logic [15:0] rom_data, ram_data, mem_wdata, char_dout, obj_dout, pal_dout;
    logic [1:0]  mem_we_n, start_button, coin_input;
    logic [8:0]  vdump;
    logic [7:0]  joystick1, joystick2, dipsw_a, dipsw_b, snd_latch, prog_data;
    logic [4:0]  prog_addr;
    logic [7:0]  op_key [16];
    logic [7:0]  dat_key [16];
    logic [1:0]  be_n_drv;
    logic [1:0]  ram_we_seen;
    logic [15:0] ram_wd_seen;
    bus_req_t    req;
    bus_rsp_t    rsp;
    bus_rsp_t    r;

    s16_main DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] rom_model(input logic [23:1] a);
        return {a[8:1], a[16:9]} ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] ram_model(input logic [12:1] a, input logic v);
        return {a, 4'h9} ^ (v ? 16'h0f0f : 16'h0000);
    endfunction

    // Board order of joystick lines
    function automatic logic [7:0] joy_order(input logic [7:0] j);
        logic [7:0] o;
        o[7] = j[1];
        o[6] = j[0];
        o[5] = j[3];
        o[4] = j[2];
        o[3] = j[7];
        o[2] = j[5];
        o[1] = j[4];
        o[0] = j[6];
        return o;
    endfunction

    task automatic abort(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic bus_cycle(input logic [23:0] ba, input logic rnw, input logic [15:0] wd,
                             input fetch_kind_t kind);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req <= '{addr: ba[23:1], rnw: rnw, be_n: be_n_drv, wdata: wd, kind: kind};
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        req_valid <= 1'b0;
        do begin
            @(posedge clk);
            n++;
            if (n > 40) abort("no response to a bus cycle");
        end while (!rsp_valid);
        r = rsp;
    endtask

    task automatic read_check(input logic [23:0] ba, input fetch_kind_t kind,
                              input logic [15:0] exp, input logic berr);
        bus_cycle(ba, 1'b1, 16'h0000, kind);
        check("rsp.rdata", r.rdata, exp);
        check("rsp.berr", r.berr, berr);
    endtask

    // ROM answers after 1 to 4 cycles
    initial begin
        int d;
        forever begin
            @(posedge clk);
            if (rom_cs) begin
                d = $urandom_range(4, 1);
                repeat (d - 1) @(posedge clk);
                rom_ok   <= 1'b1;
                rom_data <= rom_model({6'd0, rom_addr});
                @(posedge clk);
                rom_ok <= 1'b0;
                while (rom_cs) @(posedge clk);
            end
        end
    end

    initial begin
        int d;
        forever begin
            @(posedge clk);
            if (ram_cs || vram_cs) begin
                ram_we_seen = mem_we_n;     // Strobes and data seen by the memory
                ram_wd_seen = mem_wdata;
                d = $urandom_range(4, 1);
                repeat (d - 1) @(posedge clk);
                ram_ok   <= 1'b1;
                ram_data <= ram_model(mem_addr, vram_cs);
                @(posedge clk);
                ram_ok <= 1'b0;
                while (ram_cs || vram_cs) @(posedge clk);
            end
        end
    end

    assign char_dout = {4'h0, mem_addr} ^ CHAR_K;
    assign obj_dout  = {4'h0, mem_addr} ^ OBJ_K;
    assign pal_dout  = {4'h0, mem_addr} ^ PAL_K;

    initial begin
        #(TEST_COUNT * 10 * CLK_PERIOD);
        abort("watchdog timeout, the test did not finish");
    end

    // Bound protocol checker
    initial begin
        wait (DUT.u_props.fail_count != 0);
        abort("a protocol assertion in the bound checker failed");
    end

    initial begin
        logic [7:0] k;
        void'($urandom(32'h8dd83bd4));
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        be_n_drv = 2'b00;
        rom_ok = 1'b0;
        rom_data = 16'h0000;
        ram_ok = 1'b0;
        ram_data = 16'h0000;
        vdump = 9'd0;
        hstart = 1'b0;
        joystick1 = 8'hff;
        joystick2 = 8'hff;
        start_button = 2'b11;
        coin_input = 2'b11;
        service = 1'b1;
        dipsw_a = 8'hff;
        dipsw_b = 8'hff;
        snd_ack = 1'b0;
        dec_en = 1'b0;
        prog_we = 1'b0;
        prog_addr = 5'd0;
        prog_data = 8'h00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("irq_n", irq_n, 1'b1);
        check("flip", flip, 1'b1);
        check("snd_irqn", snd_irqn, 1'b1);
        check("colscr_en", colscr_en, 1'b1);
        check("rowscr_en", rowscr_en, 1'b1);

        // Every region, raw ROM
        read_check(24'h012346, fetch_data, rom_model(23'h0091a3), 1'b0);
        read_check(24'h401a2e, fetch_data, ram_model(12'hd17, 1'b1), 1'b0);
        read_check(24'hc70b5c, fetch_data, ram_model(12'h5ae, 1'b0), 1'b0);
        check("mem_we_n", ram_we_seen, 2'b11);
        read_check(24'h410200, fetch_data, 16'h0100 ^ CHAR_K, 1'b0);
        read_check(24'h440010, fetch_data, 16'h0008 ^ OBJ_K, 1'b0);
        read_check(24'h840ffe, fetch_data, 16'h07ff ^ PAL_K, 1'b0);
        read_check(24'hc60000, fetch_data, 16'hffff, 1'b0);
        read_check(24'h040000, fetch_data, 16'hffff, 1'b1);
        read_check(24'hff0000, fetch_data, 16'hffff, 1'b1);
        be_n_drv = 2'b10;       // Lower byte only
        bus_cycle(24'hc70010, 1'b0, 16'h1234, fetch_data);
        be_n_drv = 2'b00;
        check("rsp.rdata", r.rdata, 16'hffff);
        check("mem_we_n", ram_we_seen, 2'b10);
        check("mem_wdata", ram_wd_seen, 16'h1234);

        // Key tables, top address bit picks the data half
        for (int j = 0; j < 32; j++) begin
            k = 8'($urandom);
            if (j < 16) op_key[j] = k;
            else dat_key[j - 16] = k;
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 5'(j);
            prog_data <= k;
        end
        @(posedge clk);
        prog_we <= 1'b0;
        dec_en  <= 1'b1;
        read_check(24'h000024, fetch_op, rom_model(23'h12) ^ {2{op_key[2]}}, 1'b0);
        read_check(24'h000024, fetch_data, rom_model(23'h12) ^ {2{dat_key[2]}}, 1'b0);
        read_check(24'h01a35e, fetch_op, rom_model(23'hd1af) ^ {2{op_key[15]}}, 1'b0);
        read_check(24'h03fffa, fetch_data, rom_model(23'h1fffd) ^ {2{dat_key[13]}}, 1'b0);
        @(posedge clk);
        dec_en <= 1'b0;
        read_check(24'h01a35e, fetch_op, rom_model(23'hd1af), 1'b0);

        // Cabinet inputs and DIP switches
        @(posedge clk);
        joystick1    <= 8'($urandom);
        joystick2    <= 8'($urandom);
        start_button <= 2'($urandom);
        coin_input   <= 2'($urandom);
        service      <= 1'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
        @(posedge clk);
        read_check(24'hc41000, fetch_data,
                   {10'h3ff, start_button, service, 1'b1, coin_input}, 1'b0);
        read_check(24'hc41002, fetch_data, {8'hff, joy_order(joystick1)}, 1'b0);
        read_check(24'hc41006, fetch_data, {8'hff, joy_order(joystick2)}, 1'b0);
        read_check(24'hc42000, fetch_data, {8'hff, dipsw_a}, 1'b0);
        read_check(24'hc42002, fetch_data, {8'hff, dipsw_b}, 1'b0);
        read_check(24'hc41004, fetch_data, 16'hffff, 1'b0);
        read_check(24'hc43000, fetch_data, 16'hffff, 1'b0);
        read_check(24'hc40006, fetch_data, 16'hffff, 1'b0);

        // Port block
        bus_cycle(24'hc40000, 1'b0, 16'h005a, fetch_data);
        bus_cycle(24'hc40002, 1'b0, 16'h0000, fetch_data);
        bus_cycle(24'hc40004, 1'b0, 16'h0002, fetch_data);
        check("snd_latch", snd_latch, 8'h5a);
        check("flip", flip, 1'b0);
        check("snd_irqn", snd_irqn, 1'b0);
        check("colscr_en", colscr_en, 1'b0);
        check("rowscr_en", rowscr_en, 1'b1);
        @(posedge clk);
        snd_ack <= 1'b1;
        read_check(24'hc40004, fetch_data, 16'hff42, 1'b0);

        // VBLANK interrupt
        @(posedge clk);
        vdump  <= 9'd100;
        hstart <= 1'b1;
        repeat (2) @(posedge clk);
        hstart <= 1'b0;
        check("irq_n", irq_n, 1'b1);
        vdump <= 9'd223;
        @(posedge clk);
        hstart <= 1'b1;
        repeat (2) @(posedge clk);
        hstart <= 1'b0;
        check("irq_n", irq_n, 1'b0);
        read_check(24'hfffff0, fetch_iack, 16'hffff, 1'b0);
        check("irq_n", irq_n, 1'b1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- files.f
hdl/s16_pkg.sv
hdl/s16_addr_dec.sv
hdl/s16_bus_ctrl.sv
hdl/s16_cab_io.sv
hdl/s16_rom_dec.sv
hdl/s16_vblank_irq.sv
hdl/s16_main.sv
bench/s16_main_properties.sv
bench/s16_main_tb.sv
